/* src.f */
rtl/wh_pkg.sv
rtl/wh_piso.sv
rtl/wh_stream_control.sv
rtl/wh_link_skid.sv
rtl/wh_stream_in.sv
verif/wh_clk_gen.sv
verif/wh_stream_check.sv
verif/wh_stream_in_tb.sv

/* verif/wh_stream_in_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module wh_stream_in_tb
  import wh_pkg::*;
();

  localparam int num_pkts_lp   = 40;
  localparam int wait_limit_lp = 300;

  logic                     clk;
  logic                     rst_n;
  wh_hdr_u                  hdr;
  logic                     hdr_v;
  logic                     hdr_ready;
  logic [data_width_lp-1:0] data;
  logic                     data_v;
  logic                     data_ready;
  logic [flit_width_lp-1:0] link_data;
  logic                     link_v;
  logic                     link_ready;
  int                       chk_errs;
  int                       pending;

  logic [31:0] lcg_state = 32'd28;
  int          beats_q[$];
  int          timeouts = 0;
  int          tb_errs = 0;
  int          cyc;

  wh_clk_gen clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  wh_stream_in dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .hdr_i        (hdr),
    .hdr_v_i      (hdr_v),
    .hdr_ready_o  (hdr_ready),
    .data_i       (data),
    .data_v_i     (data_v),
    .data_ready_o (data_ready),
    .link_data_o  (link_data),
    .link_v_o     (link_v),
    .link_ready_i (link_ready)
  );

  wh_stream_check chk0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .hdr_i        (hdr),
    .hdr_v_i      (hdr_v),
    .hdr_ready_i  (hdr_ready),
    .data_i       (data),
    .data_v_i     (data_v),
    .data_ready_i (data_ready),
    .link_data_i  (link_data),
    .link_v_i     (link_v),
    .link_ready_i (link_ready),
    .err_cnt_o    (chk_errs),
    .pending_o    (pending)
  );

  // 32 bit LCG whose callers take the upper bits
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // link takes a flit about three cycles out of four
  always @(negedge clk)
  begin
    link_ready = (lcg_next() >> 30) != 0;
  end

  task automatic send_headers();
    logic [31:0] r;
    int          n;
    int          wait_cyc;
    bit          got;
    for (n = 0; n < num_pkts_lp; n++)
    begin
      repeat (lcg_next() >> 30) @(negedge clk);
      r = lcg_next();
      hdr.fields.cord   = r[31:28];
      // length 0, 4, 8 or 12
      hdr.fields.len    = {r[27:26], 2'b00};
      r = lcg_next();
      hdr.fields.pr_hdr = r[31:8];
      beats_q.push_back(hdr.fields.len / data_flits_lp);
      hdr_v    = 1'b1;
      wait_cyc = 0;
      got      = 1'b0;
      while (!got && (wait_cyc < wait_limit_lp))
      begin
        @(posedge clk);
        got = hdr_ready;
        wait_cyc++;
      end
      if (!got)
      begin
        $display("timeout: header %0d was never accepted", n);
        timeouts++;
      end
      @(negedge clk);
      hdr_v = 1'b0;
    end
  endtask

  task automatic send_beats();
    int n;
    int b;
    int beats;
    int wait_cyc;
    bit got;
    for (n = 0; n < num_pkts_lp; n++)
    begin
      wait_cyc = 0;
      while ((beats_q.size() == 0) && (wait_cyc < wait_limit_lp))
      begin
        @(negedge clk);
        wait_cyc++;
      end
      if (beats_q.size() == 0)
      begin
        $display("timeout: no header offered for packet %0d", n);
        timeouts++;
        return;
      end
      beats = beats_q.pop_front();
      for (b = 0; b < beats; b++)
      begin
        repeat (lcg_next() >> 31) @(negedge clk);
        data     = {lcg_next(), lcg_next()};
        data_v   = 1'b1;
        wait_cyc = 0;
        got      = 1'b0;
        while (!got && (wait_cyc < wait_limit_lp))
        begin
          @(posedge clk);
          got = data_ready;
          wait_cyc++;
        end
        if (!got)
        begin
          $display("timeout: beat %0d of packet %0d was never accepted", b, n);
          timeouts++;
        end
        @(negedge clk);
        data_v = 1'b0;
      end
    end
  endtask

  initial
  begin
    hdr        = '0;
    hdr_v      = 1'b0;
    data       = '0;
    data_v     = 1'b0;
    link_ready = 1'b0;

    cyc = 0;
    while ((rst_n !== 1'b1) && (cyc < 50))
    begin
      @(negedge clk);
      cyc++;
    end
    if (rst_n !== 1'b1)
    begin
      $display("timeout: reset was never released");
      timeouts++;
    end
    @(negedge clk);
    // nothing offered yet, so all handshake outputs must be idle
    if ((link_v !== 1'b0) || (hdr_ready !== 1'b0) || (data_ready !== 1'b0))
    begin
      $display("ERR %0t: handshake outputs not low after reset", $time);
      tb_errs++;
    end

    fork
      send_headers();
      send_beats();
    join

    // let the buffer and the link drain
    cyc = 0;
    while ((pending != 0) && (cyc < wait_limit_lp))
    begin
      @(negedge clk);
      cyc++;
    end
    if (pending != 0)
    begin
      $display("timeout: %0d flits or beats still unmatched at the end", pending);
      timeouts++;
    end

    $display("errors %0d timeouts %0d", chk_errs + tb_errs, timeouts);
    if ((chk_errs + tb_errs == 0) && (timeouts == 0))
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/wh_stream_check.sv */
`timescale 1ns/10ps
`default_nettype none

// watches client and link ports, predicts the flit stream and compares
module wh_stream_check
  import wh_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  wh_hdr_u                  hdr_i,
  input  logic                     hdr_v_i,
  input  logic                     hdr_ready_i,
  input  logic [data_width_lp-1:0] data_i,
  input  logic                     data_v_i,
  input  logic                     data_ready_i,
  input  logic [flit_width_lp-1:0] link_data_i,
  input  logic                     link_v_i,
  input  logic                     link_ready_i,
  output int                       err_cnt_o,
  output int                       pending_o
);

  logic [flit_width_lp-1:0] exp_q[$];
  logic [flit_width_lp-1:0] act_q[$];
  logic [flit_width_lp-1:0] exp_flit;
  logic [flit_width_lp-1:0] act_flit;
  logic [flit_width_lp-1:0] prev_data;
  logic [hdr_width_lp-1:0]  hdr_word;
  logic                     prev_stall;
  int                       owed_beats;

  // flit k of a word counted from the low end
  function automatic logic [flit_width_lp-1:0] ref_flit(
    input logic [data_width_lp-1:0] word,
    input int                       k
  );
    ref_flit = word[k*flit_width_lp +: flit_width_lp];
  endfunction

  initial
  begin
    err_cnt_o  = 0;
    pending_o  = 0;
    owed_beats = 0;
    prev_stall = 1'b0;
  end

  // values read here are the ones the DUT saw at this edge
  always @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      prev_stall = 1'b0;
    end
    else
    begin
      // a stalled flit has to stay on the link unchanged
      if (prev_stall && (!link_v_i || (link_data_i !== prev_data)))
      begin
        $display("ERR %0t: stalled link flit %h dropped or changed to %h",
                 $time, prev_data, link_data_i);
        err_cnt_o++;
      end
      prev_stall = link_v_i && !link_ready_i;
      prev_data  = link_data_i;

      if (hdr_v_i && hdr_ready_i)
      begin
        // previous packet must have all its beats in the buffer
        if (owed_beats != 0)
        begin
          $display("ERR %0t: header taken with %0d beats still owed", $time, owed_beats);
          err_cnt_o++;
        end
        // rebuild the word from the decoded fields with cord lowest
        hdr_word = {hdr_i.fields.pr_hdr, hdr_i.fields.len, hdr_i.fields.cord};
        for (int k = 0; k < hdr_flits_lp; k++)
        begin
          exp_q.push_back(ref_flit(data_width_lp'(hdr_word), k));
        end
        owed_beats = hdr_i.fields.len / data_flits_lp;
      end

      if (data_v_i && data_ready_i)
      begin
        if (owed_beats == 0)
        begin
          $display("ERR %0t: data beat taken beyond header length", $time);
          err_cnt_o++;
        end
        else
        begin
          owed_beats--;
        end
        for (int k = 0; k < data_flits_lp; k++)
        begin
          exp_q.push_back(ref_flit(data_i, k));
        end
      end

      if (link_v_i && link_ready_i)
      begin
        act_q.push_back(link_data_i);
      end

      // flits of a beat leave before the beat is released, so match lazily
      while ((exp_q.size() != 0) && (act_q.size() != 0))
      begin
        exp_flit = exp_q.pop_front();
        act_flit = act_q.pop_front();
        if (act_flit !== exp_flit)
        begin
          $display("ERR %0t: link flit expected %h got %h", $time, exp_flit, act_flit);
          err_cnt_o++;
        end
      end
    end
    pending_o = exp_q.size() + act_q.size() + owed_beats;
  end

endmodule

`default_nettype wire

/* verif/wh_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// 20 ns clock, reset low for the first 8 rising edges
module wh_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    // release away from the rising edge
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

  always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* rtl/wh_stream_in.sv */
`timescale 1ns/10ps
`default_nettype none

// sending half of a wormhole port
// one header word and its data beats go out as a stream of link flits
module wh_stream_in
  import wh_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // client header
  input  wh_hdr_u                  hdr_i,
  input  logic                     hdr_v_i,
  output logic                     hdr_ready_o,

  // client data beats
  input  logic [data_width_lp-1:0] data_i,
  input  logic                     data_v_i,
  output logic                     data_ready_o,

  // link
  output logic [flit_width_lp-1:0] link_data_o,
  output logic                     link_v_o,
  input  logic                     link_ready_i
);

  logic                     is_hdr;
  logic                     is_data;

  logic [flit_width_lp-1:0] hdr_flit;
  logic                     hdr_flit_v;
  logic [flit_width_lp-1:0] data_flit;
  logic                     data_flit_v;

  logic [flit_width_lp-1:0] skid_data_li;
  logic                     skid_v_li;
  logic                     skid_ready_lo;

  // header goes out flit by flit, low flit first
  wh_piso #(
    .els_p (hdr_flits_lp)
  ) hdr_piso (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (hdr_i.flits),
    .v_i     (hdr_v_i & is_hdr),
    .ready_o (hdr_ready_o),
    .data_o  (hdr_flit),
    .v_o     (hdr_flit_v),
    .ready_i (is_hdr & skid_ready_lo)
  );

  // each data beat goes out as four flits
  wh_piso #(
    .els_p (data_flits_lp)
  ) data_piso (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (data_i),
    .v_i     (data_v_i & is_data),
    .ready_o (data_ready_o),
    .data_o  (data_flit),
    .v_o     (data_flit_v),
    .ready_i (is_data & skid_ready_lo)
  );

  // header word stays put until its last flit leaves, so len is valid at capture
  wh_stream_control stream_control (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .len_i     (hdr_i.fields.len),
    .accept_i  (skid_v_li & skid_ready_lo),
    .is_hdr_o  (is_hdr),
    .is_data_o (is_data)
  );

  // pick the serializer that owns the current flit
  assign skid_data_li = is_hdr ? hdr_flit : data_flit;
  assign skid_v_li    = is_hdr ? hdr_flit_v : data_flit_v;

  wh_link_skid link_skid (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (skid_data_li),
    .v_i     (skid_v_li),
    .ready_o (skid_ready_lo),
    .data_o  (link_data_o),
    .v_o     (link_v_o),
    .ready_i (link_ready_i)
  );

endmodule

`default_nettype wire

/* rtl/wh_link_skid.sv */
`timescale 1ns/10ps
`default_nettype none

// two-entry buffer in front of the link
// outputs come straight from flops, ready toward the serializers is registered
module wh_link_skid
  import wh_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // from the serializers
  input  logic [flit_width_lp-1:0] data_i,
  input  logic                     v_i,
  output logic                     ready_o,

  // toward the link
  output logic [flit_width_lp-1:0] data_o,
  output logic                     v_o,
  input  logic                     ready_i
);

  logic [flit_width_lp-1:0] main_data_r;
  logic                     main_v_r;
  logic [flit_width_lp-1:0] spare_data_r;
  logic                     spare_v_r;

  logic                     in_fire;
  logic                     main_free;

  // spare only fills behind a stalled main entry, so spare empty means room
  assign ready_o = ~spare_v_r;
  assign in_fire = v_i & ready_o;

  // main entry is empty or leaves this cycle
  assign main_free = ~main_v_r | ready_i;

  assign data_o = main_data_r;
  assign v_o    = main_v_r;

  // control flags
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      main_v_r  <= 1'b0;
      spare_v_r <= 1'b0;
    end
    else if (main_free)
    begin
      // refill main from spare first to keep order
      main_v_r  <= spare_v_r | in_fire;
      spare_v_r <= 1'b0;
    end
    else if (in_fire)
    begin
      spare_v_r <= 1'b1;
    end
  end

  // payload registers
  always_ff @(posedge clk_i)
  begin
    if (main_free)
    begin
      main_data_r <= spare_v_r ? spare_data_r : data_i;
    end
    // park a flit that arrives while the link stalls
    if (!main_free && in_fire)
    begin
      spare_data_r <= data_i;
    end
  end

  // link side must hold its flit until taken
  a_link_hold : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (v_o && !ready_i) |=> (v_o && $stable(data_o))
  );

endmodule

`default_nettype wire

/* rtl/wh_stream_control.sv */
`timescale 1ns/10ps
`default_nettype none

// tells whether the next flit into the link buffer is header or data
module wh_stream_control
  import wh_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // length field of the header word being sent
  input  logic [len_width_lp-1:0] len_i,
  // a flit entered the link buffer
  input  logic                    accept_i,

  output logic                    is_hdr_o,
  output logic                    is_data_o
);

  // low means header state
  logic                    data_state_r;
  // header flits seen so far, then data flits still to come
  logic [len_width_lp-1:0] cnt_r;

  logic                    hdr_done;
  logic                    data_done;

  // second header flit captures the length
  assign hdr_done  = accept_i & ~data_state_r &
                     (cnt_r == len_width_lp'(hdr_flits_lp - 1));
  // final data flit of the packet
  assign data_done = accept_i & data_state_r & (cnt_r == len_width_lp'(1));

  assign is_hdr_o  = ~data_state_r;
  assign is_data_o = data_state_r;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      data_state_r <= 1'b0;
      cnt_r        <= '0;
    end
    else if (hdr_done)
    begin
      // zero length means header only, stay put for the next packet
      cnt_r        <= len_i;
      data_state_r <= (len_i != '0);
    end
    else if (data_done)
    begin
      cnt_r        <= '0;
      data_state_r <= 1'b0;
    end
    else if (accept_i)
    begin
      if (data_state_r)
      begin
        cnt_r <= cnt_r - 1'b1;
      end
      else
      begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  // data flits come in whole beats, so the loaded count fills beats exactly
  a_len_whole_beats : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    hdr_done |=> ((cnt_r % data_flits_lp) == 0)
  );

endmodule

`default_nettype wire

/* rtl/wh_piso.sv */
`timescale 1ns/10ps
`default_nettype none

// cuts one wide word into flits, low flit first
// the current flit is visible in the same cycle the word shows up
module wh_piso
  import wh_pkg::*;
#(
  parameter int els_p = 2
)
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // wide side
  input  logic [els_p*flit_width_lp-1:0]   data_i,
  input  logic                             v_i,
  output logic                             ready_o,

  // flit side
  output logic [flit_width_lp-1:0]         data_o,
  output logic                             v_o,
  input  logic                             ready_i
);

  // a single flit word still needs a one bit index
  localparam int cnt_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

  logic [cnt_width_lp-1:0] cnt_r;
  logic                    flit_fire;
  logic                    last_flit;

  // flit handshake on the narrow side
  assign flit_fire = v_o & ready_i;
  assign last_flit = (cnt_r == cnt_width_lp'(els_p - 1));

  // slice selected by the index, no extra storage
  assign data_o = data_i[cnt_r*flit_width_lp +: flit_width_lp];
  assign v_o    = v_i;

  // word is released only while its last flit is taken
  assign ready_o = flit_fire & last_flit;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      cnt_r <= '0;
    end
    else if (flit_fire)
    begin
      // wrap back for the next word
      if (last_flit)
      begin
        cnt_r <= '0;
      end
      else
      begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  // the word must not change between its first and last flit
  a_word_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (v_i && !ready_o) |=> $stable(data_i)
  );

endmodule

`default_nettype wire

/* rtl/wh_pkg.sv */
`default_nettype none

package wh_pkg;

  // link flit width, every serializer output and the skid buffer use it
  localparam int flit_width_lp = 16;

  // wormhole routing fields at the bottom of the header
  localparam int cord_width_lp = 4;
  // number of data flits that follow the header flits
  localparam int len_width_lp = 4;

  // protocol information above the routing fields
  localparam int pr_hdr_width_lp = 24;

  // full header word as offered by the client
  localparam int hdr_width_lp = cord_width_lp + len_width_lp + pr_hdr_width_lp;

  // one client data beat
  localparam int data_width_lp = 64;

  // flits needed to carry one header word
  localparam int hdr_flits_lp = hdr_width_lp / flit_width_lp;
  // flits needed to carry one data beat
  localparam int data_flits_lp = data_width_lp / flit_width_lp;

  // header word, seen either as routing fields or as link flits
  // fields: cord sits in the low bits, protocol header at the top
  // flits: entry 0 is the low flit and leaves first
  typedef union packed {
    struct packed {
      logic [pr_hdr_width_lp-1:0] pr_hdr;
      logic [len_width_lp-1:0]    len;
      logic [cord_width_lp-1:0]   cord;
    } fields;
    logic [hdr_flits_lp-1:0][flit_width_lp-1:0] flits;
  } wh_hdr_u;

endpackage

`default_nettype wire
